/* tb.f */
logic/cache_pkg.sv
logic/sync_ram.sv
logic/cache_way.sv
logic/refill_sequencer.sv
logic/cache_fsm.sv
logic/cache_top.sv
verification/clock_gen.sv
verification/mem_model.sv
verification/cache_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f tb.f --top-module cache_tb -o cache_tb
	./obj_dir/cache_tb

clean:
	rm -rf obj_dir

/* verification/cache_tb.sv */
`default_nettype none

module cache_tb
    import cache_pkg::*;
();

    localparam int WAIT_LIMIT  = 200;
    localparam int RESET_LIMIT = 50;
    localparam int NUM_ROWS    = 19;

    typedef struct packed {
        logic        op;           // 1 = store
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        expect_hit;   // line is surely resident
    } test_row_t;

    logic              clk;
    logic              reset;
    logic              valid;
    cache_req_t        req;
    logic              addr_ok;
    logic              data_ok;
    logic [WORD_W-1:0] rdata;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    logic              ret_last;
    logic [WORD_W-1:0] ret_data;
    logic              wr_req;
    logic [ADDR_W-1:0] wr_addr;
    logic [LINE_W-1:0] wr_data;
    logic              wr_rdy;
    logic [31:0]       cur_line;
    logic [31:0]       ref_mem [logic [29:0]];

    // index 0x12 gets five tags, index 0x13 a store miss
    test_row_t rows [NUM_ROWS] = '{
        '{1'b0, 32'h0001_0124, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0001_0128, 4'b0000, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0001_0124, 4'b0101, 32'hdead_beef, 1'b1},
        '{1'b0, 32'h0001_0124, 4'b0000, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0002_0138, 4'b1100, 32'h1234_5678, 1'b0},
        '{1'b0, 32'h0002_0138, 4'b0000, 32'h0000_0000, 1'b1},
        '{1'b0, 32'h0002_0130, 4'b0000, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0003_012c, 4'b1111, 32'ha5a5_0001, 1'b0},
        '{1'b1, 32'h0004_0120, 4'b0011, 32'h0000_c0de, 1'b0},
        '{1'b1, 32'h0005_0128, 4'b1000, 32'h7700_0000, 1'b0},
        '{1'b0, 32'h0001_0124, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0003_012c, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0004_0120, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0005_0128, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b1, 32'h0006_0124, 4'b0110, 32'h00ab_cd00, 1'b0},
        '{1'b0, 32'h0006_0124, 4'b0000, 32'h0000_0000, 1'b1},
        '{1'b0, 32'h0001_0120, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0003_0120, 4'b0000, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0002_0134, 4'b0000, 32'h0000_0000, 1'b0}
    };

    clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    cache_top DUT (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    // memory word before any store
    function automatic logic [31:0] fill_word(input logic [29:0] word_addr);
        logic [31:0] product;
        product = {2'b00, word_addr} * 32'h9e37_79b1;
        return product ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] ref_read(input logic [29:0] word_addr);
        if (ref_mem.exists(word_addr)) return ref_mem[word_addr];
        return fill_word(word_addr);
    endfunction

    task automatic ref_store(input logic [29:0] word_addr, input logic [3:0] strb,
                             input logic [31:0] data);
        logic [31:0] word;
        word = ref_read(word_addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[b*8 +: 8] = data[b*8 +: 8];
        end
        ref_mem[word_addr] = word;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, expected);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t while waiting for %s", $time, what);
        $display("tests failed");
        $fatal(1, "simulation stopped on timeout");
    endtask

    // bus rules that hold on every sampled cycle
    task automatic watch_bus(input logic expect_hit);
        if (rd_req) check_equal(rd_addr, cur_line, "rd_addr of refill");
        if (expect_hit) check_equal(32'(rd_req), 32'd0, "rd_req during a hit");
    endtask

    task automatic wait_addr_ok(input logic expect_hit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!addr_ok) begin
            watch_bus(expect_hit);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout("addr_ok");
            @(negedge clk);
        end
    endtask

    task automatic run_row(input int idx, input test_row_t row);
        int cycles;
        cur_line = {row.addr[31:4], 4'h0};
        @(posedge clk);
        #1;
        valid = 1'b1;
        req = '{op: row.op, tag: row.addr[31:12], index: row.addr[11:4],
                offset: row.addr[3:0], wstrb: row.wstrb, wdata: row.wdata};
        @(posedge clk);   // accept edge
        #1;
        valid = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!data_ok) begin
            watch_bus(row.expect_hit);
            cycles++;
            if (cycles > WAIT_LIMIT) report_timeout($sformatf("data_ok of row %0d", idx));
            @(negedge clk);
        end
        watch_bus(row.expect_hit);
        if (row.expect_hit) begin
            check_equal(cycles, 32'd0, $sformatf("row %0d hit latency", idx));
        end
        if (row.op) begin
            ref_store(row.addr[31:2], row.wstrb, row.wdata);
        end else begin
            check_equal(rdata, ref_read(row.addr[31:2]), $sformatf("row %0d load data", idx));
        end
        wait_addr_ok(row.expect_hit);   // a hit never reaches the bus
    endtask

    initial begin
        int cycles;
        cur_line = '0;
        valid = 1'b0;
        req = '0;
        cycles = 0;
        @(negedge clk);
        while (reset !== 1'b0) begin
            cycles++;
            if (cycles > RESET_LIMIT) report_timeout("reset release");
            @(negedge clk);
        end
        check_equal(32'(addr_ok), 32'd1, "addr_ok after reset");
        check_equal(32'(data_ok), 32'd0, "data_ok after reset");
        check_equal(32'(rd_req), 32'd0, "rd_req after reset");
        check_equal(32'(wr_req), 32'd0, "wr_req after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, rows[i]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mem_model.sv */
`default_nettype none

module mem_model
    import cache_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              rd_req,
    input  wire logic [ADDR_W-1:0] rd_addr,
    output logic                   rd_rdy,
    output logic                   ret_valid,
    output logic                   ret_last,
    output logic [WORD_W-1:0]      ret_data,
    input  wire logic              wr_req,
    input  wire logic [ADDR_W-1:0] wr_addr,
    input  wire logic [LINE_W-1:0] wr_data,
    output logic                   wr_rdy
);

    localparam logic [31:0] SEED = 32'h93c7_fa4a;

    logic [LINE_W-1:0]   lines [logic [ADDR_W-OFFSET_W-1:0]];   // only lines written back
    logic [LINE_W-1:0]   rd_line;
    logic [LINE_W-1:0]   wb_data;
    logic [27:0]         wb_line_addr;
    logic                reading;
    logic [1:0]          beat;
    int                  rd_delay;
    int                  wr_delay;

    // untouched memory word, spread over the whole word address
    function automatic logic [WORD_W-1:0] fill_word(input logic [29:0] word_addr);
        logic [31:0] product;
        product = {2'b00, word_addr} * 32'h9e37_79b1;
        return product ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [LINE_W-1:0] line_read(input logic [27:0] line_addr);
        logic [LINE_W-1:0] line;
        if (lines.exists(line_addr)) return lines[line_addr];
        for (int b = 0; b < NUM_BANKS; b++) begin
            line[b*WORD_W +: WORD_W] = fill_word({line_addr, 2'(b)});
        end
        return line;
    endfunction

    task automatic serve_write_back();
        if (wr_rdy) begin
            lines[wb_line_addr] = wb_data;   // taken at the edge just passed
            wr_rdy = 1'b0;
            wr_delay = -1;
        end else if (wr_req) begin
            if (wr_delay < 0) wr_delay = int'($urandom_range(3, 0));
            if (wr_delay == 0) begin
                wb_line_addr = wr_addr[ADDR_W-1:OFFSET_W];
                wb_data = wr_data;
                wr_rdy = 1'b1;
            end else begin
                wr_delay = wr_delay - 1;
            end
        end
    endtask

    task automatic serve_refill();
        if (rd_rdy) begin
            rd_rdy = 1'b0;
            rd_delay = -1;
            reading = 1'b1;
            beat = 2'd0;
        end else if (ret_valid) begin
            if (ret_last) reading = 1'b0;
            beat = beat + 2'd1;
        end
        ret_valid = 1'b0;
        ret_last = 1'b0;
        if (reading) begin
            if ($urandom_range(2, 0) != 0) begin   // gap about one cycle in three
                ret_valid = 1'b1;
                ret_last = (beat == 2'd3);
                ret_data = rd_line[beat*WORD_W +: WORD_W];
            end
        end else if (rd_req) begin
            if (rd_delay < 0) rd_delay = int'($urandom_range(3, 0));
            if (rd_delay == 0) begin
                rd_line = line_read(rd_addr[ADDR_W-1:OFFSET_W]);
                rd_rdy = 1'b1;
            end else begin
                rd_delay = rd_delay - 1;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        reading = 1'b0;
        beat = 2'd0;
        rd_delay = -1;
        wr_delay = -1;
        forever begin
            @(posedge clk);
            #1;
            if (reset) begin
                rd_rdy = 1'b0;
                ret_valid = 1'b0;
                ret_last = 1'b0;
                wr_rdy = 1'b0;
                reading = 1'b0;
                rd_delay = -1;
                wr_delay = -1;
            end else begin
                serve_write_back();   // write-back lands before the refill read
                serve_refill();
            end
        end
    end

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;   // released just after an edge like other inputs
    end

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    // cpu side
    input  wire logic              valid,
    input  wire cache_req_t        req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [WORD_W-1:0]      rdata,
    // bus read side
    output logic                   rd_req,
    output logic [ADDR_W-1:0]      rd_addr,
    input  wire logic              rd_rdy,
    input  wire logic              ret_valid,
    input  wire logic              ret_last,
    input  wire logic [WORD_W-1:0] ret_data,
    // bus write side
    output logic                   wr_req,
    output logic [ADDR_W-1:0]      wr_addr,
    output logic [LINE_W-1:0]      wr_data,
    input  wire logic              wr_rdy
);

    cache_state_t              state;
    cache_req_t                req_q;        // request buffer
    logic [BANK_SEL_W-1:0]     crit_bank;
    logic [BANK_SEL_W-1:0]     beat_index;
    logic                      crit_beat;
    logic                      victim_way;
    logic                      hit;
    logic                      hit_way;
    logic                      victim_dirty;
    way_status_t               way_st [2];
    way_status_t               victim_st;
    logic [LINE_W-1:0]         hit_line;
    logic [WORD_W-1:0]         refill_word;

    // hit-write holding register
    logic                      hw_way;
    logic [BANK_SEL_W-1:0]     hw_bank;
    logic [STRB_W-1:0]         hw_strb;
    logic [WORD_W-1:0]         hw_data;

    assign crit_bank = req_q.offset[OFFSET_W-1 -: BANK_SEL_W];

    always_ff @(posedge clk) begin
        if (valid && addr_ok) req_q <= req;
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && hit && req_q.op) begin
            hw_way  <= hit_way;
            hw_bank <= crit_bank;
            hw_strb <= req_q.wstrb;
            hw_data <= req_q.wdata;
        end
    end

    cache_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .req_store    (req_q.op),
        .wr_rdy       (wr_rdy),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .crit_beat    (crit_beat),
        .state        (state),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .wr_req       (wr_req)
    );

    refill_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .refilling  (state == REFILL),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .crit_bank  (crit_bank),
        .beat_index (beat_index),
        .crit_beat  (crit_beat),
        .victim_way (victim_way)
    );

    // store miss bytes go into the critical refill word
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            refill_word[b*8 +: 8] = (crit_beat && req_q.op && req_q.wstrb[b])
                                  ? req_q.wdata[b*8 +: 8] : ret_data[b*8 +: 8];
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        way_access_t acc;

        always_comb begin
            acc       = '0;
            acc.index = (state == IDLE) ? req.index : req_q.index;
            acc.wdata = (state == REFILL) ? refill_word : hw_data;
            case (state)
                IDLE: acc.bank_en = {NUM_BANKS{valid}};   // lookup reads whole line
                HIT_WRITE: begin
                    if (hw_way == 1'(w)) begin
                        acc.bank_en[hw_bank] = 1'b1;
                        acc.bank_we[hw_bank] = hw_strb;
                        acc.dirty_set        = 1'b1;
                    end
                end
                REFILL: begin
                    if (victim_way == 1'(w) && ret_valid) begin
                        acc.bank_en[beat_index] = 1'b1;
                        acc.bank_we[beat_index] = '1;
                        acc.tag_we              = crit_beat;
                        acc.dirty_set           = crit_beat && req_q.op;
                        acc.dirty_clear         = crit_beat && !req_q.op;
                    end
                end
                default: ;
            endcase
        end

        cache_way u_way (
            .clk        (clk),
            .reset      (reset),
            .access     (acc),
            .lookup_tag (req_q.tag),
            .status     (way_st[w])
        );
    end

    assign hit     = way_st[0].hit || way_st[1].hit;
    assign hit_way = way_st[1].hit;
    assign hit_line = hit_way ? way_st[1].line : way_st[0].line;
    assign rdata    = (state == REFILL) ? ret_data : hit_line[crit_bank*WORD_W +: WORD_W];

    assign victim_st    = victim_way ? way_st[1] : way_st[0];
    assign victim_dirty = victim_st.valid && victim_st.dirty;

    assign rd_addr = {req_q.tag, req_q.index, {OFFSET_W{1'b0}}};
    assign wr_addr = {victim_st.tag, req_q.index, {OFFSET_W{1'b0}}};   // held stable through MISS
    assign wr_data = victim_st.line;

endmodule

`default_nettype wire

/* logic/cache_fsm.sv */
`default_nettype none

module cache_fsm
    import cache_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic valid,
    input  wire logic hit,
    input  wire logic victim_dirty,
    input  wire logic req_store,
    input  wire logic wr_rdy,
    input  wire logic rd_rdy,
    input  wire logic ret_valid,
    input  wire logic ret_last,
    input  wire logic crit_beat,
    output cache_state_t state,
    output logic       addr_ok,
    output logic       data_ok,
    output logic       rd_req,
    output logic       wr_req
);

    cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (valid) next_state = LOOKUP;
            LOOKUP: begin
                if (!hit) begin
                    next_state = MISS;
                end else if (req_store) begin
                    next_state = HIT_WRITE;
                end else begin
                    next_state = IDLE;
                end
            end
            HIT_WRITE: next_state = IDLE;   // one cycle to write the bank
            MISS:      if (!victim_dirty || wr_rdy) next_state = REPLACE;
            REPLACE:   if (rd_rdy) next_state = REFILL;
            REFILL:    if (ret_valid && ret_last) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    assign addr_ok = (state == IDLE);
    // stores finish at lookup, load misses on the requested word
    assign data_ok = ((state == LOOKUP) && (hit || req_store))
                   || ((state == REFILL) && crit_beat && !req_store);
    assign rd_req  = (state == REPLACE);
    assign wr_req  = (state == MISS) && victim_dirty;

    // a pending write-back keeps its request up until memory takes it
    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req);

endmodule

`default_nettype wire

/* logic/refill_sequencer.sv */
`default_nettype none

module refill_sequencer
    import cache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  refilling,
    input  wire logic                  ret_valid,
    input  wire logic                  ret_last,
    input  wire logic [BANK_SEL_W-1:0] crit_bank,
    output logic [BANK_SEL_W-1:0]      beat_index,
    output logic                       crit_beat,
    output logic                       victim_way
);

    logic [2:0] lfsr;

    always_ff @(posedge clk) begin
        if (reset || !refilling) begin
            beat_index <= '0;   // each refill starts at bank 0
        end else if (ret_valid) begin
            beat_index <= beat_index + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (ret_valid && ret_last) begin
            lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    assign crit_beat  = refilling && ret_valid && (beat_index == crit_bank);
    assign victim_way = lfsr[0];

    // memory only returns data for a read the FSM issued
    a_ret_in_refill: assert property (@(posedge clk) disable iff (reset)
        ret_valid |-> refilling);

endmodule

`default_nettype wire

/* logic/cache_way.sv */
`default_nettype none

module cache_way
    import cache_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire way_access_t      access,
    input  wire logic [TAG_W-1:0] lookup_tag,
    output way_status_t           status
);

    tagv_t tag_rdata;
    tagv_t tag_wdata;
    logic  tag_en;
    word_t bank_rdata [NUM_BANKS];

    // valid and dirty live in flops so reset clears them
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    assign tag_en    = (|access.bank_en) | access.tag_we;
    assign tag_wdata = '{tag: lookup_tag, valid: 1'b1};   // refill installs the request tag

    sync_ram #(
        .entry_t (tagv_t)
    ) u_tag_ram (
        .clk   (clk),
        .en    (tag_en),
        .we    (access.tag_we),
        .addr  (access.index),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sync_ram #(
            .entry_t (word_t)
        ) u_bank_ram (
            .clk   (clk),
            .en    (access.bank_en[b]),
            .we    (access.bank_we[b]),
            .addr  (access.index),
            .wdata (access.wdata),
            .rdata (bank_rdata[b])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (access.tag_we) valid_bits[access.index] <= 1'b1;
            if (access.dirty_set) begin
                dirty_bits[access.index] <= 1'b1;
            end else if (access.dirty_clear) begin
                dirty_bits[access.index] <= 1'b0;
            end
        end
    end

    always_comb begin
        status.valid = valid_bits[access.index] && tag_rdata.valid;
        status.dirty = dirty_bits[access.index];
        status.tag   = tag_rdata.tag;
        status.hit   = status.valid && (tag_rdata.tag == lookup_tag);
        for (int b = 0; b < NUM_BANKS; b++) begin
            status.line[b*WORD_W +: WORD_W] = bank_rdata[b];
        end
    end

    // a refill of a store miss sets dirty, a load refill clears it, never both
    a_dirty_excl: assert property (@(posedge clk) disable iff (reset)
        !(access.dirty_set && access.dirty_clear));

endmodule

`default_nettype wire

/* logic/sync_ram.sv */
`default_nettype none

module sync_ram
    import cache_pkg::*;
#(
    parameter type entry_t = word_t,
    parameter int  DEPTH   = NUM_SETS,
    // byte lanes for data words, one enable for anything else
    localparam int ENTRY_W = $bits(entry_t),
    localparam int WE_W    = (ENTRY_W == WORD_W) ? STRB_W : 1
) (
    input  wire logic                     clk,
    input  wire logic                     en,
    input  wire logic [WE_W-1:0]          we,
    input  wire logic [$clog2(DEPTH)-1:0] addr,
    input  wire entry_t                   wdata,
    output entry_t                        rdata
);

    localparam int LANE_W = ENTRY_W / WE_W;

    logic [ENTRY_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < WE_W; i++) begin
                if (we[i]) begin
                    mem[addr][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
                end
            end
            rdata <= entry_t'(mem[addr]);   // read returns the old contents
        end
    end

endmodule

`default_nettype wire

/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // geometry
    localparam int WORD_W     = 32;
    localparam int LINE_W     = 128;
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 8;
    localparam int NUM_SETS   = 256;
    localparam int NUM_BANKS  = 4;
    localparam int BANK_SEL_W = 2;
    localparam int STRB_W     = 4;
    localparam int OFFSET_W   = 4;
    localparam int ADDR_W     = 32;

    localparam logic [2:0] LFSR_SEED = 3'b111;   // replacement lfsr start

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic                op;       // 1 = store
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [STRB_W-1:0]   wstrb;
        logic [WORD_W-1:0]   wdata;
    } cache_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tagv_t;

    // per-way RAM controls for one cycle
    typedef struct packed {
        logic [INDEX_W-1:0]                 index;
        logic [NUM_BANKS-1:0]               bank_en;
        logic [NUM_BANKS-1:0][STRB_W-1:0]   bank_we;
        logic [WORD_W-1:0]                  wdata;
        logic                               tag_we;
        logic                               dirty_set;
        logic                               dirty_clear;
    } way_access_t;

    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] line;
    } way_status_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_WRITE,
        MISS,
        REPLACE,
        REFILL
    } cache_state_t;

endpackage

`default_nettype wire
